/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module soc_bus_tb \
	-f soc_bus.f > sim.log 2>&1 \
	&& ./obj_dir/Vsoc_bus_tb >> sim.log 2>&1 \
	|| echo "Build or simulation returned an error" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* soc_bus.f */
verilog/soc_bus_pkg.sv
verilog/bus_addr_decode.sv
verilog/scratch_ram.sv
verilog/gamepad_reader.sv
verilog/io_registers.sv
verilog/bus_response.sv
verilog/soc_bus_top.sv
verification/soc_bus_tb.sv

/* verification/soc_bus_tb.sv */
// Testbench for the system bus, random AXI-Lite traffic and two pad models checked against a model
`timescale 1ns/1ps

module soc_bus_tb;
	logic                      clk_50mhz = 1'b0;
	logic                      resetn = 1'b0;
	soc_bus_pkg::addr_t        araddr = '0;
	logic                      arvalid = 1'b0;
	logic                      arready;
	soc_bus_pkg::addr_t        awaddr = '0;
	logic                      awvalid = 1'b0;
	logic                      awready;
	soc_bus_pkg::data_t        wdata = '0;
	soc_bus_pkg::strb_t        wstrb = '0;
	logic                      wvalid = 1'b0;
	logic                      wready;
	soc_bus_pkg::data_t        rdata;
	soc_bus_pkg::resp_t        rresp;
	logic                      rvalid;
	logic                      rready = 1'b0;
	soc_bus_pkg::resp_t        bresp;
	logic                      bvalid;
	logic                      bready = 1'b0;
	logic                      c1clock;
	logic                      c1latch;
	logic                      c1data;
	logic                      c2clock;
	logic                      c2latch;
	logic                      c2data;
	soc_bus_pkg::data_t        ram_model [soc_bus_pkg::RAM_WORDS];
	soc_bus_pkg::pad_buttons_t pad1_buttons = '0;
	soc_bus_pkg::pad_buttons_t pad2_buttons = '0;
	logic [2:0]                pad1_bit = '0;
	logic [2:0]                pad2_bit = '0;
	logic                      pad1_clock_q = 1'b0;
	logic                      pad2_clock_q = 1'b0;
	integer                    seed = 47;
	int                        cycles = 0;

	soc_bus_top soc_bus_top_i (.*);

	always #10 clk_50mhz = !clk_50mhz;

	// Pad models shift out inverted buttons starting at bit 0 on latch
	assign c1data = !pad1_buttons[pad1_bit];
	assign c2data = !pad2_buttons[pad2_bit];

	always @(negedge clk_50mhz) begin
		pad1_clock_q <= c1clock;
		pad2_clock_q <= c2clock;
		if (c1latch)
			pad1_bit <= '0;
		else if (c1clock && !pad1_clock_q && pad1_bit != 3'd7)
			pad1_bit <= pad1_bit + 3'd1;
		if (c2latch)
			pad2_bit <= '0;
		else if (c2clock && !pad2_clock_q && pad2_bit != 3'd7)
			pad2_bit <= pad2_bit + 3'd1;
	end

	// Bus traffic needs about 6k cycles and the pad wait 20480
	always @(posedge clk_50mhz) begin
		cycles <= cycles + 1;
		if (cycles == 80000) begin
			$display("Timeout: the test did not finish within 80000 clock cycles");
			$display("STATUS: FAIL");
			$fatal(1, "simulation stopped at the cycle limit");
		end
	end

	function automatic logic in_window(input soc_bus_pkg::addr_t addr,
		input soc_bus_pkg::addr_t base, input int bits);
		soc_bus_pkg::addr_t high_mask;
		high_mask = 32'hffff_ffff << bits;
		return (addr & high_mask) == (base & high_mask);
	endfunction

	// Upper window bits are random so each access goes through some alias
	function automatic soc_bus_pkg::addr_t ram_address(input soc_bus_pkg::ram_index_t idx);
		logic [5:0] alias_bits;
		alias_bits = $random(seed);
		return soc_bus_pkg::RAM_BASE | {16'h0000, alias_bits, idx, 2'b00};
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("ERROR: %s expected %0h actual %0h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "simulation stopped at the first mismatch");
		end
	endtask

	task automatic bus_access(input string name, input logic write,
		input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t data,
		input soc_bus_pkg::strb_t strb, output soc_bus_pkg::data_t rd_data,
		output soc_bus_pkg::resp_t resp, output int hs_cycle);
		int          edges;
		int          hold;
		logic [33:0] rsp_first;
		hold = $unsigned($random(seed)) % 4;
		@(posedge clk_50mhz);
		if (write) begin
			awaddr  <= addr;
			awvalid <= 1'b1;
			wdata   <= data;
			wstrb   <= strb;
			wvalid  <= 1'b1;
		end else begin
			araddr  <= addr;
			arvalid <= 1'b1;
		end
		// Ready seen high before an edge makes that edge the handshake
		@(negedge clk_50mhz);
		while (!(write ? awready && wready : arready))
			@(negedge clk_50mhz);
		@(posedge clk_50mhz);
		hs_cycle = cycles;
		arvalid <= 1'b0;
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		edges = 0;
		@(negedge clk_50mhz);
		while (!(write ? bvalid : rvalid)) begin
			check_value({name, " ready while open"}, 0, {arready, awready, wready});
			@(posedge clk_50mhz);
			edges++;
			@(negedge clk_50mhz);
		end
		check_value({name, " latency"}, 3, edges);
		rd_data = rdata;
		resp = write ? bresp : rresp;
		rsp_first = write ? {32'h0, bresp} : {rdata, rresp};
		// Master stalls and the response sits still
		repeat (hold) begin
			@(negedge clk_50mhz);
			check_value({name, " stalled response"}, rsp_first,
				write ? {32'h0, bresp} : {rdata, rresp});
			check_value({name, " stalled valid"}, 1, write ? bvalid : rvalid);
			check_value({name, " ready while stalled"}, 0, arready);
		end
		@(posedge clk_50mhz);
		rready <= !write;
		bready <= write;
		@(posedge clk_50mhz);
		rready <= 1'b0;
		bready <= 1'b0;
		@(negedge clk_50mhz);
		check_value({name, " valid after handshake"}, 0, {rvalid, bvalid});
		check_value({name, " ready after handshake"}, 0, arready);
		@(negedge clk_50mhz);
		check_value({name, " ready reopened"}, 1, arready);
	endtask

	initial begin
		soc_bus_pkg::data_t      rd;
		soc_bus_pkg::resp_t      resp;
		int                      hs;
		int                      first_hs;
		soc_bus_pkg::data_t      first_count;
		soc_bus_pkg::ram_index_t idx;
		soc_bus_pkg::strb_t      strb;
		soc_bus_pkg::data_t      wr;
		soc_bus_pkg::addr_t      addr;
		repeat (5) @(posedge clk_50mhz);
		resetn <= 1'b1;
		@(negedge clk_50mhz);
		check_value("reset state", 9'b111_000000, {arready, awready, wready, rvalid, bvalid,
			c1latch, c2latch, c1clock, c2clock});

		// Known contents for every word before random traffic
		for (int i = 0; i < soc_bus_pkg::RAM_WORDS; i++) begin
			wr = $random(seed);
			ram_model[i] = wr;
			bus_access("ram fill", 1'b1, ram_address(soc_bus_pkg::ram_index_t'(i)), wr,
				4'hf, rd, resp, hs);
			check_value("ram fill response", soc_bus_pkg::RESP_OKAY, resp);
		end
		for (int n = 0; n < 200; n++) begin
			idx = $random(seed);
			strb = $random(seed);
			wr = $random(seed);
			bus_access("ram write", 1'b1, ram_address(idx), wr, strb, rd, resp, hs);
			check_value("ram write response", soc_bus_pkg::RESP_OKAY, resp);
			for (int b = 0; b < 4; b++)
				if (strb[b])
					ram_model[idx][8*b +: 8] = wr[8*b +: 8];
			if ($random(seed) & 1) begin
				// Half of the reads return to the word just written
				if ($random(seed) & 1)
					idx = $random(seed);
				bus_access("ram read", 1'b0, ram_address(idx), '0, '0, rd, resp, hs);
				check_value("ram read data", ram_model[idx], rd);
				check_value("ram read response", soc_bus_pkg::RESP_OKAY, resp);
			end
		end

		bus_access("counter read", 1'b0, soc_bus_pkg::COUNTER_BASE, '0, '0, first_count,
			resp, first_hs);
		check_value("counter read response", soc_bus_pkg::RESP_OKAY, resp);
		repeat ($unsigned($random(seed)) % 16) @(posedge clk_50mhz);
		addr = soc_bus_pkg::COUNTER_BASE | ($random(seed) & 32'hfc);
		bus_access("counter read", 1'b0, addr, '0, '0, rd, resp, hs);
		check_value("counter read response", soc_bus_pkg::RESP_OKAY, resp);
		check_value("counter step", hs - first_hs, rd - first_count);
		bus_access("counter write", 1'b1, addr, $random(seed), 4'hf, rd, resp, hs);
		check_value("counter write response", soc_bus_pkg::RESP_SLVERR, resp);
		bus_access("gamepad write", 1'b1, soc_bus_pkg::GAMEPAD_BASE, $random(seed), 4'hf,
			rd, resp, hs);
		check_value("gamepad write response", soc_bus_pkg::RESP_SLVERR, resp);

		@(posedge clk_50mhz);
		pad1_buttons <= $random(seed);
		pad2_buttons <= $random(seed);
		// Two poll periods so one whole poll sees the new buttons
		repeat (20480) @(posedge clk_50mhz);
		bus_access("gamepad read", 1'b0, soc_bus_pkg::GAMEPAD_BASE, '0, '0, rd, resp, hs);
		check_value("gamepad read data", {16'h0000, pad2_buttons, pad1_buttons}, rd);
		check_value("gamepad read response", soc_bus_pkg::RESP_OKAY, resp);

		addr = $random(seed);
		while (in_window(addr, soc_bus_pkg::RAM_BASE, soc_bus_pkg::RAM_ADDR_BITS) ||
			in_window(addr, soc_bus_pkg::COUNTER_BASE, soc_bus_pkg::COUNTER_ADDR_BITS) ||
			in_window(addr, soc_bus_pkg::GAMEPAD_BASE, soc_bus_pkg::GAMEPAD_ADDR_BITS))
			addr = $random(seed);
		bus_access("unmapped read", 1'b0, addr, '0, '0, rd, resp, hs);
		check_value("unmapped read data", 0, rd);
		check_value("unmapped read response", soc_bus_pkg::RESP_DECERR, resp);
		bus_access("unmapped write", 1'b1, addr, $random(seed), 4'hf, rd, resp, hs);
		check_value("unmapped write response", soc_bus_pkg::RESP_DECERR, resp);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* verilog/bus_addr_decode.sv */
// Decode stage that accepts one AXI-Lite request at a time and issues an access strobe to a target
`timescale 1ns/1ps

module bus_addr_decode (
	input  logic                    clk_50mhz,
	input  logic                    resetn,
	input  soc_bus_pkg::addr_t      araddr,
	input  logic                    arvalid,
	output logic                    arready,
	input  soc_bus_pkg::addr_t      awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  soc_bus_pkg::data_t      wdata,
	input  soc_bus_pkg::strb_t      wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	input  logic                    rsp_done,
	output logic                    acc_strobe,
	output logic                    acc_write,
	output soc_bus_pkg::target_e    acc_target,
	output soc_bus_pkg::ram_index_t acc_index,
	output soc_bus_pkg::data_t      acc_wdata,
	output soc_bus_pkg::strb_t      acc_wstrb
);
	logic               busy;
	logic               rd_accept;
	logic               wr_accept;
	soc_bus_pkg::addr_t sel_addr;

	function automatic logic region_hit(
		input soc_bus_pkg::addr_t addr,
		input soc_bus_pkg::addr_t base,
		input int bits
	);
		return (addr >> bits) == (base >> bits);
	endfunction

	function automatic soc_bus_pkg::target_e decode_target(input soc_bus_pkg::addr_t addr);
		if (region_hit(addr, soc_bus_pkg::RAM_BASE, soc_bus_pkg::RAM_ADDR_BITS))
			return soc_bus_pkg::tgt_ram;
		if (region_hit(addr, soc_bus_pkg::COUNTER_BASE, soc_bus_pkg::COUNTER_ADDR_BITS))
			return soc_bus_pkg::tgt_counter;
		if (region_hit(addr, soc_bus_pkg::GAMEPAD_BASE, soc_bus_pkg::GAMEPAD_ADDR_BITS))
			return soc_bus_pkg::tgt_gamepad;
		return soc_bus_pkg::tgt_none;
	endfunction

	assign arready = !busy;
	// Read wins when both channels ask in the same cycle
	assign awready = !busy && !arvalid;
	assign wready  = !busy && !arvalid;

	assign rd_accept = arvalid && arready;
	assign wr_accept = awvalid && wvalid && awready && wready;
	assign sel_addr  = rd_accept ? araddr : awaddr;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			busy       <= 1'b0;
			acc_strobe <= 1'b0;
		end else begin
			acc_strobe <= rd_accept || wr_accept;
			if (rd_accept || wr_accept)
				busy <= 1'b1;
			else if (rsp_done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (rd_accept || wr_accept) begin
			acc_write  <= wr_accept;
			acc_target <= decode_target(sel_addr);
			// The RAM repeats inside its window
			acc_index  <= sel_addr[9:2];
			acc_wdata  <= wdata;
			acc_wstrb  <= wstrb;
		end
	end

	// Response side may only finish a transaction that decode still holds open
	a_done_while_open: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		rsp_done |-> busy && !(rd_accept || wr_accept));

endmodule

/* verilog/bus_response.sv */
// Result stage, picks the execute answer and holds it on the read or write response channel
`timescale 1ns/1ps

module bus_response (
	input  logic                 clk_50mhz,
	input  logic                 resetn,
	input  logic                 acc_strobe,
	input  logic                 acc_write,
	input  soc_bus_pkg::target_e acc_target,
	input  logic                 ram_done,
	input  soc_bus_pkg::data_t   ram_rdata,
	input  soc_bus_pkg::resp_t   ram_resp,
	input  logic                 io_done,
	input  soc_bus_pkg::data_t   io_rdata,
	input  soc_bus_pkg::resp_t   io_resp,
	input  logic                 rready,
	input  logic                 bready,
	output logic                 rvalid,
	output soc_bus_pkg::data_t   rdata,
	output soc_bus_pkg::resp_t   rresp,
	output logic                 bvalid,
	output soc_bus_pkg::resp_t   bresp,
	output logic                 rsp_done
);
	logic               none_done;
	logic               op_write;
	logic               pend;
	soc_bus_pkg::data_t sel_data;
	soc_bus_pkg::resp_t sel_resp;
	soc_bus_pkg::data_t res_data;
	soc_bus_pkg::resp_t res_resp;

	always_comb begin
		if (ram_done) begin
			sel_data = ram_rdata;
			sel_resp = ram_resp;
		end else if (io_done) begin
			sel_data = io_rdata;
			sel_resp = io_resp;
		end else begin
			sel_data = '0;
			sel_resp = soc_bus_pkg::RESP_DECERR;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			none_done <= 1'b0;
			pend      <= 1'b0;
			rvalid    <= 1'b0;
			bvalid    <= 1'b0;
			rsp_done  <= 1'b0;
		end else begin
			// Unmapped address answered alongside the execute stage
			none_done <= acc_strobe && (acc_target == soc_bus_pkg::tgt_none);
			pend      <= ram_done || io_done || none_done;
			rsp_done  <= (rvalid && rready) || (bvalid && bready);
			if (pend && !op_write)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (pend && op_write)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (acc_strobe)
			op_write <= acc_write;
		if (ram_done || io_done || none_done) begin
			res_data <= sel_data;
			res_resp <= sel_resp;
		end
		if (pend) begin
			if (op_write) begin
				bresp <= res_resp;
			end else begin
				rdata <= res_data;
				rresp <= res_resp;
			end
		end
	end

	a_read_held: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		(rvalid && !rready) |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* verilog/gamepad_reader.sv */
// Polls two serial gamepads over shared latch and clock timing and holds their button states
`timescale 1ns/1ps

module gamepad_reader (
	input  logic                      clk_50mhz,
	input  logic                      resetn,
	input  logic                      c1data,
	input  logic                      c2data,
	output logic                      c1clock,
	output logic                      c1latch,
	output logic                      c2clock,
	output logic                      c2latch,
	output soc_bus_pkg::pad_buttons_t pad1_state,
	output soc_bus_pkg::pad_buttons_t pad2_state
);
	soc_bus_pkg::pad_phase_e                phase;
	logic [soc_bus_pkg::PAD_DIV_BITS-1:0]   div;
	logic [soc_bus_pkg::PAD_TICK_BITS-1:0]  tick_cnt;
	logic [2:0]                             bit_cnt;
	logic                                   tick;
	soc_bus_pkg::pad_buttons_t              shift1;
	soc_bus_pkg::pad_buttons_t              shift2;

	// Last cycle of each pad tick
	assign tick = &div;

	assign c1latch = (phase == soc_bus_pkg::latch);
	assign c2latch = (phase == soc_bus_pkg::latch);
	assign c1clock = (phase == soc_bus_pkg::shift_high);
	assign c2clock = (phase == soc_bus_pkg::shift_high);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div        <= '0;
			phase      <= soc_bus_pkg::idle;
			tick_cnt   <= '0;
			bit_cnt    <= '0;
			shift1     <= '0;
			shift2     <= '0;
			pad1_state <= '0;
			pad2_state <= '0;
		end else begin
			div <= div + 1'b1;
			if (tick) begin
				tick_cnt <= tick_cnt + 1'b1;
				case (phase)
					soc_bus_pkg::idle: begin
						if (int'(tick_cnt) == soc_bus_pkg::PAD_POLL_TICKS - 1) begin
							// End of poll, both pads commit together
							phase      <= soc_bus_pkg::latch;
							tick_cnt   <= '0;
							pad1_state <= shift1;
							pad2_state <= shift2;
						end
					end
					soc_bus_pkg::latch: begin
						phase   <= soc_bus_pkg::shift_low;
						bit_cnt <= '0;
					end
					soc_bus_pkg::shift_low: begin
						// Pad data is active low
						shift1[bit_cnt] <= !c1data;
						shift2[bit_cnt] <= !c2data;
						phase           <= soc_bus_pkg::shift_high;
					end
					soc_bus_pkg::shift_high: begin
						if (bit_cnt == 3'd7) begin
							phase <= soc_bus_pkg::idle;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							phase   <= soc_bus_pkg::shift_low;
						end
					end
					default: phase <= soc_bus_pkg::idle;
				endcase
			end
		end
	end

	a_latch_clock_apart: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		!((c1latch || c2latch) && (c1clock || c2clock)));

endmodule

/* verilog/io_registers.sv */
// Execute stage I/O, read-only cycle counter and gamepad button register
`timescale 1ns/1ps

module io_registers (
	input  logic                 clk_50mhz,
	input  logic                 resetn,
	input  logic                 acc_strobe,
	input  logic                 acc_write,
	input  soc_bus_pkg::target_e acc_target,
	input  logic                 c1data,
	input  logic                 c2data,
	output logic                 io_done,
	output soc_bus_pkg::data_t   io_rdata,
	output soc_bus_pkg::resp_t   io_resp,
	output logic                 c1clock,
	output logic                 c1latch,
	output logic                 c2clock,
	output logic                 c2latch
);
	soc_bus_pkg::data_t        cycle_count;
	soc_bus_pkg::pad_buttons_t pad1_state;
	soc_bus_pkg::pad_buttons_t pad2_state;
	logic                      hit;

	assign hit = acc_strobe && (acc_target == soc_bus_pkg::tgt_counter ||
		acc_target == soc_bus_pkg::tgt_gamepad);

	gamepad_reader gamepad_reader_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.c1data(c1data), .c2data(c2data),
		.c1clock(c1clock), .c1latch(c1latch), .c2clock(c2clock), .c2latch(c2latch),
		.pad1_state(pad1_state), .pad2_state(pad2_state)
	);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			cycle_count <= '0;
			io_done     <= 1'b0;
		end else begin
			cycle_count <= cycle_count + 1'b1;
			io_done     <= hit;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (hit) begin
			if (acc_write) begin
				io_rdata <= '0;
				io_resp  <= soc_bus_pkg::RESP_SLVERR;
			end else begin
				io_resp <= soc_bus_pkg::RESP_OKAY;
				if (acc_target == soc_bus_pkg::tgt_counter)
					io_rdata <= cycle_count;
				else
					io_rdata <= {16'h0000, pad2_state, pad1_state};
			end
		end
	end

endmodule

/* verilog/scratch_ram.sv */
// Execute stage scratch RAM, word array with byte strobes answering one access per strobe
`timescale 1ns/1ps

module scratch_ram (
	input  logic                    clk_50mhz,
	input  logic                    resetn,
	input  logic                    acc_strobe,
	input  logic                    acc_write,
	input  soc_bus_pkg::target_e    acc_target,
	input  soc_bus_pkg::ram_index_t acc_index,
	input  soc_bus_pkg::data_t      acc_wdata,
	input  soc_bus_pkg::strb_t      acc_wstrb,
	output logic                    ram_done,
	output soc_bus_pkg::data_t      ram_rdata,
	output soc_bus_pkg::resp_t      ram_resp
);
	soc_bus_pkg::data_t mem [soc_bus_pkg::RAM_WORDS];
	logic               hit;

	assign hit = acc_strobe && (acc_target == soc_bus_pkg::tgt_ram);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			ram_done <= 1'b0;
		else
			ram_done <= hit;
	end

	always_ff @(posedge clk_50mhz) begin
		if (hit) begin
			if (acc_write) begin
				for (int b = 0; b < $bits(soc_bus_pkg::strb_t); b++) begin
					if (acc_wstrb[b])
						mem[acc_index][8*b +: 8] <= acc_wdata[8*b +: 8];
				end
			end
			// Old word on a write, ignored by the response stage
			ram_rdata <= mem[acc_index];
			ram_resp  <= soc_bus_pkg::RESP_OKAY;
		end
	end

endmodule

/* verilog/soc_bus_pkg.sv */
// Bus widths, address map, response codes and state encodings shared by all system bus blocks
package soc_bus_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;
	typedef logic [7:0]  ram_index_t;
	// One bit per button, 1 when pressed
	typedef logic [7:0]  pad_buttons_t;

	typedef enum logic [1:0] {
		tgt_ram,
		tgt_counter,
		tgt_gamepad,
		tgt_none
	} target_e;

	typedef enum logic [1:0] {
		idle,
		latch,
		shift_low,
		shift_high
	} pad_phase_e;

	// Address map, a region matches on the bits above its width
	localparam addr_t RAM_BASE          = 32'h0201_0000;
	localparam int    RAM_ADDR_BITS     = 16;
	localparam addr_t GAMEPAD_BASE      = 32'h0200_0200;
	localparam int    GAMEPAD_ADDR_BITS = 2;
	localparam addr_t COUNTER_BASE      = 32'h0200_0300;
	localparam int    COUNTER_ADDR_BITS = 8;

	localparam int RAM_WORDS = 256;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	localparam resp_t RESP_DECERR = 2'd3;

	localparam int PAD_DIV_BITS   = 9;
	localparam int PAD_POLL_TICKS = 20;
	localparam int PAD_TICK_BITS  = $clog2(PAD_POLL_TICKS);

endpackage

/* verilog/soc_bus_top.sv */
// Top level of the system bus, one AXI-Lite port in front of RAM, counter and gamepads
`timescale 1ns/1ps

module soc_bus_top (
	input  logic               clk_50mhz,
	input  logic               resetn,
	input  soc_bus_pkg::addr_t araddr,
	input  logic               arvalid,
	output logic               arready,
	input  soc_bus_pkg::addr_t awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  soc_bus_pkg::data_t wdata,
	input  soc_bus_pkg::strb_t wstrb,
	input  logic               wvalid,
	output logic               wready,
	output soc_bus_pkg::data_t rdata,
	output soc_bus_pkg::resp_t rresp,
	output logic               rvalid,
	input  logic               rready,
	output soc_bus_pkg::resp_t bresp,
	output logic               bvalid,
	input  logic               bready,
	output logic               c1clock,
	output logic               c1latch,
	input  logic               c1data,
	output logic               c2clock,
	output logic               c2latch,
	input  logic               c2data
);
	logic                    acc_strobe;
	logic                    acc_write;
	soc_bus_pkg::target_e    acc_target;
	soc_bus_pkg::ram_index_t acc_index;
	soc_bus_pkg::data_t      acc_wdata;
	soc_bus_pkg::strb_t      acc_wstrb;
	logic                    ram_done;
	soc_bus_pkg::data_t      ram_rdata;
	soc_bus_pkg::resp_t      ram_resp;
	logic                    io_done;
	soc_bus_pkg::data_t      io_rdata;
	soc_bus_pkg::resp_t      io_resp;
	logic                    rsp_done;

	bus_addr_decode bus_addr_decode_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.rsp_done(rsp_done),
		.acc_strobe(acc_strobe), .acc_write(acc_write), .acc_target(acc_target),
		.acc_index(acc_index), .acc_wdata(acc_wdata), .acc_wstrb(acc_wstrb)
	);

	scratch_ram scratch_ram_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.acc_strobe(acc_strobe), .acc_write(acc_write), .acc_target(acc_target),
		.acc_index(acc_index), .acc_wdata(acc_wdata), .acc_wstrb(acc_wstrb),
		.ram_done(ram_done), .ram_rdata(ram_rdata), .ram_resp(ram_resp)
	);

	io_registers io_registers_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.acc_strobe(acc_strobe), .acc_write(acc_write), .acc_target(acc_target),
		.c1data(c1data), .c2data(c2data),
		.io_done(io_done), .io_rdata(io_rdata), .io_resp(io_resp),
		.c1clock(c1clock), .c1latch(c1latch), .c2clock(c2clock), .c2latch(c2latch)
	);

	bus_response bus_response_i (
		.clk_50mhz(clk_50mhz), .resetn(resetn),
		.acc_strobe(acc_strobe), .acc_write(acc_write), .acc_target(acc_target),
		.ram_done(ram_done), .ram_rdata(ram_rdata), .ram_resp(ram_resp),
		.io_done(io_done), .io_rdata(io_rdata), .io_resp(io_resp),
		.rready(rready), .bready(bready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp),
		.bvalid(bvalid), .bresp(bresp), .rsp_done(rsp_done)
	);

endmodule
